// File: sources.f
+incdir+tb
rtl/rv_exec_pkg.sv
rtl/rv_decode.sv
rtl/rv_alu.sv
rtl/rv_muldiv.sv
rtl/rv_result.sv
rtl/rv_exec_unit.sv
tb/tb_rv_exec_unit.sv

// File: Bender.yml
package:
  name: rv_exec_unit

sources:
  - rtl/rv_exec_pkg.sv
  - rtl/rv_decode.sv
  - rtl/rv_alu.sv
  - rtl/rv_muldiv.sv
  - rtl/rv_result.sv
  - rtl/rv_exec_unit.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_rv_exec_unit.sv

// File: tb/tb_rv_ref.svh
`ifndef TB_RV_REF_SVH
`define TB_RV_REF_SVH

logic [31:0] rng_state = 32'd74;

function automatic logic [31:0] xorshift32();
  logic [31:0] x;
  x = rng_state;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  rng_state = x;
  return x;
endfunction

// Extreme values show up about one time in three
function automatic logic [31:0] pick_operand();
  logic [31:0] r;
  r = xorshift32();
  case (r[2:0])
    3'd0: return 32'h8000_0000;
    3'd1: return 32'hffff_ffff;
    3'd2: return 32'h0000_0000;
    default: return xorshift32();
  endcase
endfunction

function automatic logic [2:0] funct3_of(input exec_op_e op);
  case (op)
    op_add, op_sub, op_mul: return 3'd0;
    op_sll, op_mulh: return 3'd1;
    op_slt, op_mulhsu: return 3'd2;
    op_sltu, op_mulhu: return 3'd3;
    op_xor, op_div: return 3'd4;
    op_srl, op_sra, op_divu: return 3'd5;
    op_or, op_rem: return 3'd6;
    default: return 3'd7;
  endcase
endfunction

function automatic logic [6:0] funct7_of(input exec_op_e op);
  if (op inside {op_sub, op_sra}) begin
    return funct7_alt;
  end else if (op >= op_mul) begin
    return funct7_muldiv;
  end else begin
    return funct7_base;
  end
endfunction

function automatic logic [31:0] r_type(input exec_op_e op, input logic [4:0] rd);
  return {funct7_of(op), 5'd2, 5'd1, funct3_of(op), rd, opc_op};
endfunction

function automatic logic [31:0] i_type(input exec_op_e op, input logic [4:0] rd,
                                       input logic [11:0] imm);
  logic [11:0] f;
  f = (op inside {op_sll, op_srl, op_sra}) ? {funct7_of(op), imm[4:0]} : imm;  // Shamt form
  return {f, 5'd1, funct3_of(op), rd, opc_op_imm};
endfunction

// Expected writeback from the RV32IM rules for OP and OP-IMM
function automatic result_t ref_exec(input logic [31:0] word, input logic [31:0] a,
                                     input logic [31:0] rs2);
  logic [6:0]  f7;
  logic [2:0]  f3;
  logic        is_imm;
  logic [31:0] b;
  logic [63:0] xa;
  logic [63:0] xb;
  logic [63:0] prod;
  logic        ovf;
  logic        bad;
  logic [31:0] d;
  result_t     r;
  f7     = word[31:25];
  f3     = word[14:12];
  is_imm = (word[6:0] == opc_op_imm);
  b      = is_imm ? {{20{word[31]}}, word[31:20]} : rs2;
  ovf    = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
  bad    = 1'b0;
  d      = '0;
  if (word[6:0] != opc_op && !is_imm) begin
    bad = 1'b1;
  end else if (!is_imm && f7 == funct7_muldiv) begin
    xa   = {{32{a[31] && (f3 == 3'd1 || f3 == 3'd2)}}, a};
    xb   = {{32{b[31] && (f3 == 3'd1)}}, b};
    prod = xa * xb;                            // Low 64 bits are exact
    if (f3 == 3'd0) d = prod[31:0];
    else if (f3 <= 3'd3) d = prod[63:32];
    else if (b == '0) d = f3[1] ? a : 32'hffff_ffff;
    else if (f3 == 3'd5) d = a / b;
    else if (f3 == 3'd7) d = a % b;
    else if (ovf) d = (f3 == 3'd4) ? a : 32'h0;
    else if (f3 == 3'd4) d = $signed(a) / $signed(b);
    else d = $signed(a) % $signed(b);
  end else begin
    if (!is_imm) bad = (f7 != funct7_base) && !(f7 == funct7_alt && f3 inside {3'd0, 3'd5});
    else if (f3 == 3'd1) bad = (f7 != funct7_base);
    else if (f3 == 3'd5) bad = (f7 != funct7_base) && (f7 != funct7_alt);
    case (f3)
      3'd0: d = (!is_imm && f7 == funct7_alt) ? a - b : a + b;
      3'd1: d = a << b[4:0];
      3'd2: d = {31'b0, $signed(a) < $signed(b)};
      3'd3: d = {31'b0, a < b};
      3'd4: d = a ^ b;
      3'd5: begin
        if (f7 == funct7_alt) d = $signed(a) >>> b[4:0];
        else d = a >> b[4:0];
      end
      3'd6: d = a | b;
      default: d = a & b;
    endcase
  end
  r.rd      = word[11:7];
  r.data    = bad ? 32'h0 : d;
  r.wr_en   = !bad && (word[11:7] != 5'd0);
  r.illegal = bad;
  return r;
endfunction

`endif

// File: tb/tb_rv_exec_unit.sv
`timescale 1ns/1ps

module tb_rv_exec_unit import rv_exec_pkg::*; ();

  localparam int reset_cycles = 16;
  localparam int mix_count    = 500;
  localparam int max_cycles   = reset_cycles + mix_count * 70 + 200;

  typedef struct packed {
    result_t     res;
    logic        fixed_lat;                   // ALU or illegal, done in 2 cycles
    logic [31:0] issue_cycle;
  } expect_t;

  logic        clk;
  logic        rst_n;
  logic        in_valid;
  logic [31:0] instr;
  logic [31:0] rs1_data;
  logic [31:0] rs2_data;
  logic        busy;
  logic        out_valid;
  result_t     result;

  expect_t     expect_q[$];
  expect_t     head;
  int unsigned cycle = 0;
  int unsigned issued = 0;
  int unsigned completed = 0;

  `include "tb_rv_ref.svh"

  rv_exec_unit UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .instr     (instr),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .busy      (busy),
    .out_valid (out_valid),
    .result    (result)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string msg);
    abort_run($sformatf("** Error [%0t ns]: %s", $time, msg));
  endtask

  task automatic check_result(input result_t got, input result_t want);
    if (got.rd !== want.rd) report_mismatch($sformatf("rd is %0d, expected %0d", got.rd, want.rd));
    else if (got.data !== want.data)
      report_mismatch($sformatf("data is %h, expected %h", got.data, want.data));
    else if (got.wr_en !== want.wr_en)
      report_mismatch($sformatf("wr_en is %b, expected %b", got.wr_en, want.wr_en));
    else if (got.illegal !== want.illegal)
      report_mismatch($sformatf("illegal is %b, expected %b", got.illegal, want.illegal));
  endtask

  task automatic compare_flag(input string name, input logic got, input logic want);
    if (got !== want) report_mismatch($sformatf("%s is %b, expected %b", name, got, want));
  endtask

  task automatic check_idle(input logic busy_v, input logic valid_v);
    compare_flag("busy", busy_v, 1'b0);
    compare_flag("out_valid", valid_v, 1'b0);
  endtask

  // Called on a falling edge, returns once the result has been checked
  task automatic issue(input logic [31:0] word, input logic [31:0] a, input logic [31:0] b);
    expect_t e;
    e.res         = ref_exec(word, a, b);
    e.fixed_lat   = e.res.illegal || (word[6:0] != opc_op) || (word[31:25] != funct7_muldiv);
    e.issue_cycle = cycle;
    expect_q.push_back(e);
    issued++;
    instr    = word;
    rs1_data = a;
    rs2_data = b;
    in_valid = 1'b1;
    @(negedge clk);
    in_valid = 1'b0;
    @(negedge clk);
    if (!e.fixed_lat) compare_flag("busy", busy, 1'b1);
    while (completed != issued) @(negedge clk);
    compare_flag("busy", busy, 1'b0);
  endtask

  task automatic reg_op(input exec_op_e op, input logic [31:0] a, input logic [31:0] b);
    issue(r_type(op, 5'(xorshift32())), a, b);
  endtask

  task automatic imm_op(input exec_op_e op, input logic [31:0] a, input logic [11:0] imm);
    issue(i_type(op, 5'(xorshift32()), imm), a, xorshift32());  // rs2 must be ignored
  endtask

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= max_cycles) begin
      abort_run($sformatf("Timed out: the run did not finish within %0d cycles", max_cycles));
    end
  end

  always @(posedge clk) begin
    if (rst_n && out_valid) begin
      if (expect_q.size() == 0) begin
        abort_run("out_valid pulsed while no instruction was outstanding");
      end else begin
        head = expect_q.pop_front();
        if (head.fixed_lat && (cycle - head.issue_cycle != 2)) begin
          report_mismatch($sformatf("out_valid came %0d cycles after in_valid, expected 2",
                                    cycle - head.issue_cycle));
        end
        check_result(result, head.res);
        completed++;
      end
    end
  end

  initial begin
    logic [31:0] sel;
    rst_n    = 1'b0;
    in_valid = 1'b0;
    instr    = '0;
    rs1_data = '0;
    rs2_data = '0;
    repeat (reset_cycles) begin
      @(negedge clk);
      check_idle(busy, out_valid);
    end
    rst_n = 1'b1;
    repeat (4) begin
      @(negedge clk);
      check_idle(busy, out_valid);
    end
    reg_op(op_add, 32'h7fff_ffff, 32'h1);
    reg_op(op_sub, 32'h0, 32'h1);
    reg_op(op_slt, 32'h8000_0000, 32'h1);
    reg_op(op_sltu, 32'h8000_0000, 32'h1);
    reg_op(op_sra, 32'h8000_00f0, 32'h24);     // Only b[4:0] counts
    reg_op(op_sll, 32'h1, 32'h1f);
    imm_op(op_add, 32'h10, 12'hfff);
    imm_op(op_sra, 32'hf000_0000, 12'h4);
    imm_op(op_sltu, 32'h5, 12'hfff);
    repeat (200) begin
      sel = xorshift32();
      if (sel[0]) reg_op(exec_op_e'(sel[31:8] % 10), pick_operand(), pick_operand());
      else imm_op(exec_op_e'(sel[31:8] % 10), pick_operand(), 12'(xorshift32()));
    end
    reg_op(op_mulh, 32'h8000_0000, 32'h8000_0000);
    reg_op(op_mulhsu, 32'h8000_0000, 32'hffff_ffff);
    reg_op(op_mulhu, 32'hffff_ffff, 32'hffff_ffff);
    reg_op(op_mul, 32'hffff_ffff, 32'h8000_0000);
    repeat (40) begin
      sel = xorshift32();
      reg_op(exec_op_e'(int'(op_mul) + sel[1:0]), pick_operand(), pick_operand());
    end
    reg_op(op_div, 32'h8000_0000, 32'hffff_ffff);
    reg_op(op_rem, 32'h8000_0000, 32'hffff_ffff);
    reg_op(op_div, 32'h1234, 32'h0);
    reg_op(op_divu, 32'h8000_0001, 32'h0);
    reg_op(op_rem, 32'hffff_fff9, 32'h0);
    reg_op(op_remu, 32'h7, 32'h0);
    reg_op(op_div, 32'hffff_fff9, 32'h2);
    reg_op(op_rem, 32'hffff_fff9, 32'h2);
    repeat (60) begin
      sel = xorshift32();
      reg_op(exec_op_e'(int'(op_div) + sel[1:0]), pick_operand(), pick_operand());
    end
    issue(32'h0000_2083, 32'h1, 32'h2);         // Load word, not executed here
    issue({funct7_alt, 5'd2, 5'd1, 3'b001, 5'd3, opc_op}, 32'h5, 32'h6);
    issue({7'h7f, 5'd2, 5'd1, 3'b000, 5'd3, opc_op}, 32'h5, 32'h6);
    issue({funct7_alt, 5'd3, 5'd1, 3'b001, 5'd4, opc_op_imm}, 32'h5, 32'h6);
    issue({7'h10, 5'd3, 5'd1, 3'b101, 5'd4, opc_op_imm}, 32'h5, 32'h6);
    issue(r_type(op_add, 5'd0), 32'h1, 32'h2);
    issue(r_type(op_mul, 5'd0), 32'h3, 32'h4);
    issue(i_type(op_add, 5'd0, 12'h5), 32'h1, 32'h0);
    repeat (mix_count) begin
      sel = xorshift32();
      case (sel[1:0])
        2'd0: reg_op(exec_op_e'(sel[31:8] % 10), pick_operand(), pick_operand());
        2'd1: imm_op(exec_op_e'(sel[31:8] % 10), pick_operand(), 12'(xorshift32()));
        2'd2: reg_op(exec_op_e'(int'(op_mul) + sel[4:2]), pick_operand(), pick_operand());
        default: issue(xorshift32(), pick_operand(), pick_operand());
      endcase
    end
    repeat (4) @(negedge clk);
    if (expect_q.size() != 0) begin
      abort_run($sformatf("%0d expected results never came out of the DUT", expect_q.size()));
    end else begin
      $display("Simulation finished: PASS");
      $finish;
    end
  end

endmodule

// File: rtl/rv_exec_unit.sv
`timescale 1ns/1ps

module rv_exec_unit import rv_exec_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            in_valid,
  input  logic [31:0]     instr,
  input  logic [xlen-1:0] rs1_data,
  input  logic [xlen-1:0] rs2_data,
  output logic            busy,
  output logic            out_valid,
  output result_t         result
);

  logic            dec_valid;
  exec_op_t        dec_op;
  logic [xlen-1:0] alu_data;
  logic            md_done;
  logic [xlen-1:0] md_data;

  rv_decode u_decode (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .instr     (instr),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .dec_valid (dec_valid),
    .dec_op    (dec_op)
  );

  rv_alu u_alu (
    .dec_op   (dec_op),
    .alu_data (alu_data)
  );

  rv_muldiv u_muldiv (
    .clk       (clk),
    .rst_n     (rst_n),
    .dec_valid (dec_valid),
    .dec_op    (dec_op),
    .busy      (busy),
    .md_done   (md_done),
    .md_data   (md_data)
  );

  rv_result u_result (
    .clk       (clk),
    .rst_n     (rst_n),
    .dec_valid (dec_valid),
    .dec_op    (dec_op),
    .alu_data  (alu_data),
    .md_done   (md_done),
    .md_data   (md_data),
    .out_valid (out_valid),
    .result    (result)
  );

endmodule

// File: rtl/rv_result.sv
`timescale 1ns/1ps

module rv_result import rv_exec_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            dec_valid,
  input  exec_op_t        dec_op,
  input  logic [xlen-1:0] alu_data,
  input  logic            md_done,
  input  logic [xlen-1:0] md_data,
  output logic            out_valid,
  output result_t         result
);

  logic       alu_done;
  logic [4:0] pend_rd;                        // rd of running muldiv op

  assign alu_done = dec_valid && !dec_op.is_muldiv;  // Illegal ops land here too

  always_ff @(posedge clk) begin
    if (dec_valid && dec_op.is_muldiv) begin
      pend_rd <= dec_op.rd;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= alu_done || md_done;
    end
  end

  always_ff @(posedge clk) begin
    if (alu_done) begin
      result <= '{rd: dec_op.rd,
                  data: dec_op.illegal ? '0 : alu_data,
                  wr_en: !dec_op.illegal && (dec_op.rd != 5'd0),
                  illegal: dec_op.illegal};
    end else if (md_done) begin
      result <= '{rd: pend_rd, data: md_data, wr_en: (pend_rd != 5'd0), illegal: 1'b0};
    end
  end

  a_one_source: assert property (@(posedge clk) disable iff (!rst_n)
    !(alu_done && md_done));

endmodule

// File: rtl/rv_muldiv.sv
`timescale 1ns/1ps

module rv_muldiv import rv_exec_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            dec_valid,
  input  exec_op_t        dec_op,
  output logic            busy,
  output logic            md_done,
  output logic [xlen-1:0] md_data
);

  typedef enum logic [1:0] {
    st_idle,
    st_mul,
    st_div
  } md_state_e;

  md_state_e         state_q;
  logic [cnt_w-1:0]  cnt_q;
  exec_op_e          op_q;
  logic [2*xlen-1:0] x_q;
  logic [2*xlen-1:0] y_q;
  logic [2*xlen-1:0] acc_q;
  logic              neg_q_q;
  logic              neg_r_q;

  logic            start;
  logic            start_mul;
  logic            sx_a;
  logic            sx_b;
  logic            a_neg;
  logic            b_neg;
  logic [xlen-1:0] mag_a;
  logic [xlen-1:0] mag_b;
  logic            div_zero;
  logic            div_ovf;
  logic [xlen-1:0] q_fix;
  logic [xlen-1:0] r_fix;

  assign start     = dec_valid && dec_op.is_muldiv;
  assign start_mul = dec_op.op inside {op_mul, op_mulh, op_mulhsu, op_mulhu};
  assign sx_a      = dec_op.a[xlen-1] && (dec_op.op inside {op_mulh, op_mulhsu});
  assign sx_b      = dec_op.b[xlen-1] && (dec_op.op == op_mulh);

  assign a_neg = dec_op.a[xlen-1] && (dec_op.op inside {op_div, op_rem});
  assign b_neg = dec_op.b[xlen-1] && (dec_op.op inside {op_div, op_rem});
  assign mag_a = a_neg ? -dec_op.a : dec_op.a;
  assign mag_b = b_neg ? -dec_op.b : dec_op.b;

  assign div_zero = (dec_op.b == '0);
  assign div_ovf  = (dec_op.op inside {op_div, op_rem}) &&
                    (dec_op.a == {1'b1, {(xlen-1){1'b0}}}) && (dec_op.b == '1);

  // Sign fix-up of the magnitude results
  assign q_fix = neg_q_q ? -acc_q[xlen-1:0] : acc_q[xlen-1:0];
  assign r_fix = neg_r_q ? -x_q[xlen-1:0] : x_q[xlen-1:0];

  assign busy = (state_q != st_idle);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= st_idle;
      cnt_q   <= '0;
      md_done <= 1'b0;
    end else begin
      md_done <= 1'b0;
      case (state_q)
        st_idle: begin
          if (start && start_mul) begin
            state_q <= st_mul;
            cnt_q   <= (dec_op.op == op_mul) ? cnt_w'(mul_lo_steps) : cnt_w'(mul_hi_steps);
          end else if (start) begin
            state_q <= st_div;
            cnt_q   <= (div_zero || div_ovf) ? '0 : cnt_w'(div_steps);  // Specials skip loop
          end
        end
        default: begin
          if (cnt_q == '0) begin
            state_q <= st_idle;
            md_done <= 1'b1;
          end else begin
            cnt_q <= cnt_q - 1'b1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    case (state_q)
      st_idle: begin
        if (start) begin
          op_q    <= dec_op.op;
          neg_q_q <= (a_neg ^ b_neg) && !div_zero && !div_ovf;
          neg_r_q <= a_neg && !div_zero && !div_ovf;
          if (start_mul) begin
            acc_q <= '0;
            x_q   <= {{xlen{sx_a}}, dec_op.a};
            y_q   <= {{xlen{sx_b}}, dec_op.b};
          end else if (div_zero) begin
            acc_q <= {{xlen{1'b0}}, {xlen{1'b1}}};   // Quotient all ones
            x_q   <= {{xlen{1'b0}}, dec_op.a};       // Remainder is dividend
            y_q   <= '0;
          end else if (div_ovf) begin
            acc_q <= {{xlen{1'b0}}, dec_op.a};
            x_q   <= '0;
            y_q   <= '0;
          end else begin
            acc_q <= '0;
            x_q   <= {{xlen{1'b0}}, mag_a};
            y_q   <= {1'b0, mag_b, {(xlen-1){1'b0}}};
          end
        end
      end
      st_mul: begin
        if (cnt_q != '0) begin
          if (y_q[0]) begin
            acc_q <= acc_q + x_q;
          end
          x_q <= x_q << 1;
          y_q <= y_q >> 1;
        end else begin
          md_data <= (op_q == op_mul) ? acc_q[xlen-1:0] : acc_q[2*xlen-1:xlen];
        end
      end
      default: begin
        if (cnt_q != '0) begin
          if (x_q >= y_q) begin
            x_q   <= x_q - y_q;
            acc_q <= {acc_q[2*xlen-2:0], 1'b1};
          end else begin
            acc_q <= {acc_q[2*xlen-2:0], 1'b0};
          end
          y_q <= y_q >> 1;
        end else begin
          md_data <= (op_q inside {op_div, op_divu}) ? q_fix : r_fix;
        end
      end
    endcase
  end

  // New work must wait until the unit is idle
  a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
    dec_valid |-> !busy);

  a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    md_done |=> !md_done);

endmodule

// File: rtl/rv_alu.sv
`timescale 1ns/1ps

module rv_alu import rv_exec_pkg::*; (
  input  exec_op_t        dec_op,
  output logic [xlen-1:0] alu_data
);

  logic [4:0]      shamt;
  logic [xlen-1:0] a;
  logic [xlen-1:0] b;

  assign a     = dec_op.a;
  assign b     = dec_op.b;
  assign shamt = dec_op.b[4:0];

  always_comb begin
    case (dec_op.op)
      op_add: begin
        alu_data = a + b;
      end
      op_sub: begin
        alu_data = a - b;
      end
      op_sll: begin
        alu_data = a << shamt;
      end
      op_slt: begin
        alu_data = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
      end
      op_sltu: begin
        alu_data = {{(xlen-1){1'b0}}, a < b};
      end
      op_xor: begin
        alu_data = a ^ b;
      end
      op_srl: begin
        alu_data = a >> shamt;
      end
      op_sra: begin
        alu_data = $signed(a) >>> shamt;     // Arithmetic, keeps sign
      end
      op_or: begin
        alu_data = a | b;
      end
      op_and: begin
        alu_data = a & b;
      end
      default: begin
        alu_data = '0;                        // M ops go through rv_muldiv
      end
    endcase
  end

endmodule

// File: rtl/rv_decode.sv
`timescale 1ns/1ps

module rv_decode import rv_exec_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            in_valid,
  input  logic [31:0]     instr,
  input  logic [xlen-1:0] rs1_data,
  input  logic [xlen-1:0] rs2_data,
  output logic            dec_valid,
  output exec_op_t        dec_op
);

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [xlen-1:0] imm;
  exec_op_e        op_d;
  logic [xlen-1:0] b_d;
  logic            muldiv_d;
  logic            illegal_d;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign imm    = {{(xlen-12){instr[31]}}, instr[31:20]};  // Low 5 bits are shamt for shifts

  always_comb begin
    op_d      = op_add;
    b_d       = rs2_data;
    muldiv_d  = 1'b0;
    illegal_d = 1'b0;
    case (opcode)
      opc_op: begin
        if (funct7 == funct7_base) begin
          case (funct3)
            3'b000: op_d = op_add;
            3'b001: op_d = op_sll;
            3'b010: op_d = op_slt;
            3'b011: op_d = op_sltu;
            3'b100: op_d = op_xor;
            3'b101: op_d = op_srl;
            3'b110: op_d = op_or;
            default: op_d = op_and;
          endcase
        end else if (funct7 == funct7_alt) begin
          case (funct3)
            3'b000: op_d = op_sub;
            3'b101: op_d = op_sra;
            default: illegal_d = 1'b1;
          endcase
        end else if (funct7 == funct7_muldiv) begin
          muldiv_d = 1'b1;
          case (funct3)
            3'b000: op_d = op_mul;
            3'b001: op_d = op_mulh;
            3'b010: op_d = op_mulhsu;
            3'b011: op_d = op_mulhu;
            3'b100: op_d = op_div;
            3'b101: op_d = op_divu;
            3'b110: op_d = op_rem;
            default: op_d = op_remu;
          endcase
        end else begin
          illegal_d = 1'b1;
        end
      end
      opc_op_imm: begin
        b_d = imm;
        case (funct3)
          3'b000: op_d = op_add;
          3'b010: op_d = op_slt;
          3'b011: op_d = op_sltu;
          3'b100: op_d = op_xor;
          3'b110: op_d = op_or;
          3'b111: op_d = op_and;
          3'b001: begin
            op_d      = op_sll;
            illegal_d = (funct7 != funct7_base);
          end
          default: begin                      // srli / srai
            op_d      = (funct7 == funct7_alt) ? op_sra : op_srl;
            illegal_d = (funct7 != funct7_base) && (funct7 != funct7_alt);
          end
        endcase
      end
      default: illegal_d = 1'b1;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    dec_op <= '{op: op_d, a: rs1_data, b: b_d, rd: instr[11:7],
                is_muldiv: muldiv_d, illegal: illegal_d};
  end

endmodule

// File: rtl/rv_exec_pkg.sv
package rv_exec_pkg;

  localparam int xlen = 32;
  localparam int cnt_w = 7;                   // Holds up to 64 iterations

  localparam logic [6:0] opc_op        = 7'b0110011;
  localparam logic [6:0] opc_op_imm    = 7'b0010011;
  localparam logic [6:0] funct7_base   = 7'b0000000;
  localparam logic [6:0] funct7_alt    = 7'b0100000;  // sub, sra, srai
  localparam logic [6:0] funct7_muldiv = 7'b0000001;

  localparam int mul_lo_steps = 32;
  localparam int mul_hi_steps = 64;           // Full 64-bit product needed
  localparam int div_steps    = 32;

  typedef enum logic [4:0] {
    op_add,
    op_sub,
    op_sll,
    op_slt,
    op_sltu,
    op_xor,
    op_srl,
    op_sra,
    op_or,
    op_and,
    op_mul,
    op_mulh,
    op_mulhsu,
    op_mulhu,
    op_div,
    op_divu,
    op_rem,
    op_remu
  } exec_op_e;

  // Decoded instruction as handed to the execute blocks
  typedef struct packed {
    exec_op_e            op;
    logic [xlen-1:0]     a;
    logic [xlen-1:0]     b;                   // rs2 or sign-extended imm
    logic [4:0]          rd;
    logic                is_muldiv;
    logic                illegal;
  } exec_op_t;

  // Writeback record
  typedef struct packed {
    logic [4:0]          rd;
    logic [xlen-1:0]     data;
    logic                wr_en;
    logic                illegal;
  } result_t;

endpackage
